// File: soc_bus.f
logic/soc_pkg.sv
logic/bram_mem.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/clint_timer.sv
logic/bus_decoder.sv
logic/soc_bus_top.sv
tests/soc_bus_assert.sv
tests/soc_bus_tb.sv

// File: tests/soc_bus_tb.sv
`timescale 1ns/10ps

module soc_bus_tb
    import soc_pkg::*;
();

    localparam int CLK_PERIOD       = 10;
    localparam int BUS_WAIT_LIMIT   = 4;
    localparam int BRAM_ACCESSES    = 200;
    localparam int BRAM_WINDOW      = 32;
    localparam int UART_BYTE_CYCLES = 12 * 10 * BAUD_DIV;
    localparam int TIMER_CYCLES     = 2000;
    localparam int WATCHDOG_CYCLES  =
        2 * (BRAM_ACCESSES * 4 + 3 * UART_BYTE_CYCLES + TIMER_CYCLES);

    typedef struct packed {
        logic     check;
        bus_rsp_t rsp;
    } pending_t;

    logic     clk;
    logic     resetn;
    logic     req_valid;
    bus_req_t req;
    logic     req_ready;
    bus_rsp_t rsp;
    logic     uart_line;
    logic     irq_soft;
    logic     irq_timer;

    data_t    bram_model [BRAM_WORDS];
    pending_t exp_q [$];
    pending_t cur_exp;
    logic     irq_timer_at_req;
    int       errors;
    int       checks;
    int       tests_run;

    soc_bus_top u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp       (rsp),
        .uart_rx   (uart_line),
        .uart_tx   (uart_line),
        .irq_soft  (irq_soft),
        .irq_timer (irq_timer)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic target_e map_target(addr_t a);
        if (a < BRAM_BASE + BRAM_WORDS * 4) return T_BRAM;
        if (a == UART_TX_ADDR) return T_UTX;
        if (a == UART_RX_ADDR) return T_URX;
        if (a == UART_LSR_ADDR) return T_LSR;
        if (a >= CLINT_BASE && a < CLINT_BASE + 32'h0001_0000) return T_CLINT;
        if (a == FREQ_ADDR) return T_FREQ;
        return T_FAULT;
    endfunction

    // bram reads return the word before the write merges in
    function automatic bus_rsp_t expect_rsp(bus_req_t r);
        bus_rsp_t   e;
        word_addr_t idx;
        e = '0;
        idx = r.addr[BRAM_AW+1:2];
        case (map_target(r.addr))
            T_BRAM: begin
                e.rdata = bram_model[idx];
                for (int i = 0; i < 4; i++) begin
                    if (r.wstrb[i]) bram_model[idx][i*8 +: 8] = r.wdata[i*8 +: 8];
                end
            end
            // modeled as empty, a full read is checked by the test
            T_URX:   e.rdata = '1;
            T_FREQ:  e.rdata = SYS_CLK_HZ;
            T_FAULT: e.fault = 1'b1;
            default: e = '0;
        endcase
        return e;
    endfunction

    function automatic bus_req_t make_req(addr_t a, data_t d, strb_t s);
        bus_req_t r;
        r.addr  = a;
        r.wdata = d;
        r.wstrb = s;
        return r;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_data(string name, data_t got, data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests_run++;
        $display("test %s finished, %0d errors", name, errors - err_before);
    endtask

    // every ready pulse retires the oldest expectation
    always @(negedge clk) begin
        if (resetn && req_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("req_ready pulsed at %0t ns with no request outstanding", $time);
            end else begin
                cur_exp = exp_q.pop_front();
                if (cur_exp.check) begin
                    check_data("rsp.rdata", rsp.rdata, cur_exp.rsp.rdata);
                    check_flag("rsp.fault", rsp.fault, cur_exp.rsp.fault);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // bus master
    //////////////////////////////////////////////////

    task automatic bus_access(input bus_req_t r, input logic check, output bus_rsp_t got);
        pending_t p;
        int       waited;
        @(negedge clk);
        req_valid        = 1'b1;
        req              = r;
        irq_timer_at_req = irq_timer;
        p.check          = check;
        p.rsp            = expect_rsp(r);
        exp_q.push_back(p);
        waited = 0;
        got    = '0;
        do begin
            @(negedge clk);
            waited++;
        end while (!req_ready && waited < BUS_WAIT_LIMIT);
        req_valid = 1'b0;
        if (req_ready) begin
            got = rsp;
            checks++;
            if (waited != 1) begin
                errors++;
                $display("req_ready for address %h came after %0d cycles instead of 1",
                         r.addr, waited);
            end
        end else begin
            errors++;
            $display("no req_ready within %0d cycles for address %h at %0t ns",
                     BUS_WAIT_LIMIT, r.addr, $time);
            void'(exp_q.pop_back());
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic bram_random_rw();
        bus_rsp_t got;
        int       err_before;
        addr_t    a;
        err_before = errors;
        // known contents first, pattern from the full byte address
        for (int w = 0; w < BRAM_WINDOW; w++) begin
            a = BRAM_BASE + addr_t'(w * 4);
            bus_access(make_req(a, a * 32'h9E37_79B1 ^ 32'h5A5A_0F0F, 4'hF), 1'b0, got);
        end
        for (int n = 0; n < BRAM_ACCESSES; n++) begin
            a = BRAM_BASE + addr_t'($urandom_range(0, BRAM_WINDOW - 1) * 4);
            bus_access(make_req(a, $urandom(), strb_t'($urandom_range(0, 15))), 1'b1, got);
        end
        report_test("bram_random_rw", err_before);
    endtask

    task automatic address_map_faults();
        bus_rsp_t got;
        int       err_before;
        addr_t    a;
        err_before = errors;
        for (int n = 0; n < 20; n++) begin
            do begin
                a = $urandom();
            end while (map_target(a) != T_FAULT);
            bus_access(make_req(a, '0, '0), 1'b1, got);
        end
        bus_access(make_req(FREQ_ADDR, '0, '0), 1'b1, got);
        bus_access(make_req(FREQ_ADDR, 32'h0000_1234, 4'hF), 1'b1, got);
        bus_access(make_req(FREQ_ADDR, '0, '0), 1'b1, got);
        report_test("address_map_faults", err_before);
    endtask

    task automatic uart_loopback();
        bus_rsp_t got;
        int       err_before;
        int       polls;
        byte_t    b;
        err_before = errors;
        for (int n = 0; n < 3; n++) begin
            b = byte_t'($urandom());
            // the stop bit may still be on the line after the previous byte
            polls = 0;
            do begin
                bus_access(make_req(UART_LSR_ADDR, '0, '0), 1'b0, got);
                polls++;
            end while (!got.rdata[LSR_TX_IDLE] && polls < BAUD_DIV);
            check_flag("lsr tx idle bit 5", got.rdata[LSR_TX_IDLE], 1'b1);
            check_flag("lsr tx idle bit 6", got.rdata[LSR_TX_IDLE+1], 1'b1);
            bus_access(make_req(UART_TX_ADDR, data_t'(b), 4'h1), 1'b1, got);
            polls = 0;
            do begin
                bus_access(make_req(UART_LSR_ADDR, '0, '0), 1'b0, got);
                polls++;
            end while (!got.rdata[LSR_RX_READY] && polls < UART_BYTE_CYCLES / 2);
            if (!got.rdata[LSR_RX_READY]) begin
                errors++;
                $display("byte %h was sent but never showed up in the receiver", b);
            end
            bus_access(make_req(UART_RX_ADDR, '0, '0), 1'b0, got);
            check_byte("rx byte", got.rdata[7:0], b);
            check_data("rx word", got.rdata, data_t'(b));
            // empty now, the model expects all ones
            bus_access(make_req(UART_RX_ADDR, '0, '0), 1'b1, got);
        end
        report_test("uart_loopback", err_before);
    endtask

    task automatic soft_irq_toggle();
        bus_rsp_t got;
        int       err_before;
        err_before = errors;
        bus_access(make_req(CLINT_BASE + MSIP_OFS, 32'd1, 4'hF), 1'b0, got);
        check_flag("irq_soft", irq_soft, 1'b1);
        bus_access(make_req(CLINT_BASE + MSIP_OFS, '0, '0), 1'b0, got);
        check_data("msip", got.rdata, 32'd1);
        bus_access(make_req(CLINT_BASE + MSIP_OFS, 32'd0, 4'hF), 1'b0, got);
        check_flag("irq_soft", irq_soft, 1'b0);
        bus_access(make_req(CLINT_BASE + MSIP_OFS, '0, '0), 1'b0, got);
        check_data("msip", got.rdata, 32'd0);
        report_test("soft_irq_toggle", err_before);
    endtask

    task automatic timer_compare();
        bus_rsp_t got;
        int       err_before;
        int       reads;
        logic     reached;
        err_before = errors;
        bus_access(make_req(CLINT_BASE + MTIME_OFS, 32'd0, 4'hF), 1'b0, got);
        bus_access(make_req(CLINT_BASE + MTIMECMP_OFS, 32'd100, 4'hF), 1'b0, got);
        reads   = 0;
        reached = 1'b0;
        // irq sampled at request time lines up with the mtime value read
        while (!reached && reads < TIMER_CYCLES / 2) begin
            bus_access(make_req(CLINT_BASE + MTIME_OFS, '0, '0), 1'b0, got);
            reads++;
            if (got.rdata < 32'd100) begin
                check_flag("irq_timer", irq_timer_at_req, 1'b0);
            end else begin
                check_flag("irq_timer", irq_timer_at_req, 1'b1);
                reached = 1'b1;
            end
        end
        if (!reached) begin
            errors++;
            $display("mtime never reached 100 within %0d reads", reads);
        end
        bus_access(make_req(CLINT_BASE + MTIMECMP_OFS, '1, 4'hF), 1'b0, got);
        check_flag("irq_timer", irq_timer, 1'b0);
        report_test("timer_compare", err_before);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        void'($urandom(69));
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        bram_random_rw();
        address_map_faults();
        uart_loopback();
        soft_irq_toggle();
        timer_compare();
        @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived", exp_q.size());
        end
        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run stopped by watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tests/soc_bus_assert.sv
`timescale 1ns/10ps

module soc_bus_assert
    import soc_pkg::*;
(
    input logic  clk,
    input logic  resetn,
    input logic  req_valid,
    input logic  req_ready,
    input logic  irq_timer,
    input data_t mtime,
    input data_t mtimecmp
);

    //////////////////////////////////////////////////
    // bus handshake
    //////////////////////////////////////////////////

    a_ready_single: assert property (
        @(posedge clk) disable iff (!resetn) req_ready |=> !req_ready
    ) else $error("req_ready high two cycles in a row");

    // a fresh request gets ready on the next cycle
    a_ready_follows: assert property (
        @(posedge clk) disable iff (!resetn) (req_valid && !req_ready) |=> req_ready
    ) else $error("req_ready did not follow req_valid by one cycle");

    a_ready_cause: assert property (
        @(posedge clk) disable iff (!resetn) req_ready |-> $past(req_valid)
    ) else $error("req_ready without a request in the cycle before");

    //////////////////////////////////////////////////
    // timer interrupt
    //////////////////////////////////////////////////

    a_irq_timer: assert property (
        @(posedge clk) disable iff (!resetn) irq_timer |-> (mtime >= mtimecmp)
    ) else $error("irq_timer high while mtime is below mtimecmp");

endmodule

bind soc_bus_top soc_bus_assert u_assert (
    .clk       (clk),
    .resetn    (resetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .irq_timer (irq_timer),
    .mtime     (u_clint.mtime),
    .mtimecmp  (u_clint.mtimecmp)
);

// File: logic/soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top
    import soc_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     req_valid,
    input  bus_req_t req,
    output logic     req_ready,
    output bus_rsp_t rsp,
    input  logic     uart_rx,
    output logic     uart_tx,
    output logic     irq_soft,
    output logic     irq_timer
);

    // bram side
    strb_t      bram_we;
    word_addr_t bram_addr;
    data_t      bram_rdata;

    // uart side
    logic  tx_load;
    byte_t tx_data;
    logic  tx_busy;
    logic  rx_pop;
    logic  rx_full;
    byte_t rx_data;

    // clint side
    logic        clint_sel;
    logic        clint_we;
    logic [15:0] clint_ofs;
    data_t       clint_wdata;
    data_t       clint_rdata;

    bus_decoder u_decoder (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .bram_we     (bram_we),
        .bram_addr   (bram_addr),
        .bram_rdata  (bram_rdata),
        .tx_load     (tx_load),
        .tx_data     (tx_data),
        .tx_busy     (tx_busy),
        .rx_pop      (rx_pop),
        .rx_full     (rx_full),
        .rx_data     (rx_data),
        .clint_sel   (clint_sel),
        .clint_we    (clint_we),
        .clint_ofs   (clint_ofs),
        .clint_wdata (clint_wdata),
        .clint_rdata (clint_rdata)
    );

    bram_mem u_bram (
        .clk   (clk),
        .we    (bram_we),
        .addr  (bram_addr),
        .wdata (req.wdata),
        .rdata (bram_rdata)
    );

    uart_tx u_uart_tx (
        .clk    (clk),
        .resetn (resetn),
        .load   (tx_load),
        .data   (tx_data),
        .tx     (uart_tx),
        .busy   (tx_busy)
    );

    uart_rx u_uart_rx (
        .clk    (clk),
        .resetn (resetn),
        .rx     (uart_rx),
        .pop    (rx_pop),
        .full   (rx_full),
        .data   (rx_data)
    );

    clint_timer u_clint (
        .clk       (clk),
        .resetn    (resetn),
        .sel       (clint_sel),
        .we        (clint_we),
        .ofs       (clint_ofs),
        .wdata     (clint_wdata),
        .rdata     (clint_rdata),
        .irq_soft  (irq_soft),
        .irq_timer (irq_timer)
    );

endmodule

// File: logic/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        req_valid,
    input  bus_req_t    req,
    output logic        req_ready,
    output bus_rsp_t    rsp,
    output strb_t       bram_we,
    output word_addr_t  bram_addr,
    input  data_t       bram_rdata,
    output logic        tx_load,
    output byte_t       tx_data,
    input  logic        tx_busy,
    output logic        rx_pop,
    input  logic        rx_full,
    input  byte_t       rx_data,
    output logic        clint_sel,
    output logic        clint_we,
    output logic [15:0] clint_ofs,
    output data_t       clint_wdata,
    input  data_t       clint_rdata
);

    target_e tgt;
    target_e rsp_tgt;
    logic    ready_q;
    logic    take;
    logic    is_wr;
    logic    rx_full_q;
    byte_t   rx_data_q;

    // new request only when no ready is pending
    assign take  = req_valid && !ready_q;
    assign is_wr = |req.wstrb;

    always_comb begin
        tgt = T_NONE;
        if (req_valid) begin
            if (req.addr[31:BRAM_AW+2] == BRAM_BASE[31:BRAM_AW+2])
                tgt = T_BRAM;
            else if (req.addr == UART_TX_ADDR)
                tgt = T_UTX;
            else if (req.addr == UART_RX_ADDR)
                tgt = T_URX;
            else if (req.addr == UART_LSR_ADDR)
                tgt = T_LSR;
            else if (req.addr[31:16] == CLINT_BASE[31:16])
                tgt = T_CLINT;
            else if (req.addr == FREQ_ADDR)
                tgt = T_FREQ;
            else
                tgt = T_FAULT;
        end
    end

    //////////////////////////////////////////////////
    // peripheral strobes, first request cycle only
    //////////////////////////////////////////////////

    assign bram_we     = (take && tgt == T_BRAM) ? req.wstrb : '0;
    assign bram_addr   = req.addr[BRAM_AW+1:2];
    assign tx_load     = take && tgt == T_UTX && is_wr;
    assign tx_data     = req.wdata[7:0];
    assign rx_pop      = take && tgt == T_URX && !is_wr;
    assign clint_sel   = take && tgt == T_CLINT;
    assign clint_we    = clint_sel && is_wr;
    assign clint_ofs   = req.addr[15:0];
    assign clint_wdata = req.wdata;

    // the registered target marks the response cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready_q <= 1'b0;
            rsp_tgt <= T_NONE;
        end else begin
            ready_q <= take;
            rsp_tgt <= take ? tgt : T_NONE;
        end
    end

    // rx state as seen at the pop, full is gone by the response cycle
    always_ff @(posedge clk) begin
        if (take && tgt == T_URX) begin
            rx_full_q <= rx_full;
            rx_data_q <= rx_data;
        end
    end

    assign req_ready = ready_q;

    //////////////////////////////////////////////////
    // response mux
    //////////////////////////////////////////////////

    always_comb begin
        rsp = '0;
        case (rsp_tgt)
            T_BRAM:  rsp.rdata = bram_rdata;
            T_URX:   rsp.rdata = rx_full_q ? data_t'(rx_data_q) : '1;
            T_LSR: begin
                rsp.rdata[LSR_TX_IDLE +: 2] = {2{!tx_busy}};
                rsp.rdata[LSR_RX_READY]     = rx_full;
            end
            T_CLINT: rsp.rdata = clint_rdata;
            T_FREQ:  rsp.rdata = SYS_CLK_HZ;
            T_FAULT: rsp.fault = 1'b1;
            default: rsp = '0;
        endcase
    end

endmodule

// File: logic/clint_timer.sv
`timescale 1ns/10ps

module clint_timer
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        sel,
    input  logic        we,
    input  logic [15:0] ofs,
    input  data_t       wdata,
    output data_t       rdata,
    output logic        irq_soft,
    output logic        irq_timer
);

    data_t     mtime;
    data_t     mtimecmp;
    logic      msip;
    tick_cnt_t tick_cnt;
    logic      tick;
    data_t     mtime_nxt;
    data_t     mtimecmp_nxt;
    logic      wr;

    assign wr   = sel && we;
    assign tick = (tick_cnt == tick_cnt_t'(TICK_DIV - 1));

    //////////////////////////////////////////////////
    // next register values
    //////////////////////////////////////////////////

    always_comb begin
        mtime_nxt    = tick ? mtime + 1'b1 : mtime;
        mtimecmp_nxt = mtimecmp;
        if (wr && ofs == MTIME_OFS) mtime_nxt = wdata;
        if (wr && ofs == MTIMECMP_OFS) mtimecmp_nxt = wdata;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tick_cnt  <= '0;
            mtime     <= '0;
            mtimecmp  <= '1;
            msip      <= 1'b0;
            irq_timer <= 1'b0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            mtime    <= mtime_nxt;
            mtimecmp <= mtimecmp_nxt;
            if (wr && ofs == MSIP_OFS) msip <= wdata[0];
            // compare on next values so irq lines up with the registers
            irq_timer <= (mtime_nxt >= mtimecmp_nxt);
        end
    end

    assign irq_soft = msip;

    // registered read, unknown offsets give zero
    always_ff @(posedge clk) begin
        if (sel) begin
            case (ofs)
                MSIP_OFS:     rdata <= data_t'(msip);
                MTIMECMP_OFS: rdata <= mtimecmp;
                MTIME_OFS:    rdata <= mtime;
                default:      rdata <= '0;
            endcase
        end
    end

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/10ps

module uart_rx
    import soc_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  rx,
    input  logic  pop,
    output logic  full,
    output byte_t data
);

    logic       rx_s1;
    logic       rx_s2;
    rx_state_e  state;
    baud_cnt_t  cnt;
    logic [2:0] bit_cnt;
    byte_t      shreg;
    logic       half_end;
    logic       bit_end;
    logic       got_byte;

    assign half_end = (cnt == baud_cnt_t'(HALF_DIV - 1));
    assign bit_end  = (cnt == baud_cnt_t'(BAUD_DIV - 1));
    // good stop bit at its middle
    assign got_byte = (state == RX_STOP) && bit_end && rx_s2;

    // two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
        end
    end

    //////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s2) state <= RX_START;
                end
                RX_START: begin
                    // recheck at mid start bit, glitches go back to idle
                    if (half_end) begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= rx_s2 ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        shreg   <= {rx_s2, shreg[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    // low stop bit drops the frame
                    if (bit_end) state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // holding register, a new byte overwrites an unread one
    always_ff @(posedge clk) begin
        if (got_byte) data <= shreg;
    end

    always_ff @(posedge clk) begin
        if (!resetn) full <= 1'b0;
        else if (got_byte) full <= 1'b1;
        else if (pop) full <= 1'b0;
    end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/10ps

module uart_tx
    import soc_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  load,
    input  byte_t data,
    output logic  tx,
    output logic  busy
);

    tx_state_e state;
    baud_cnt_t baud_cnt;
    logic [2:0] bit_cnt;
    byte_t     shreg;
    logic      bit_end;

    assign bit_end = (baud_cnt == baud_cnt_t'(BAUD_DIV - 1));
    assign busy    = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            baud_cnt <= (state == TX_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    // a load while busy never gets here and is lost
                    if (load) begin
                        shreg <= data;
                        tx    <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx      <= shreg[0];
                        bit_cnt <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            tx    <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            // lsb first
                            tx      <= shreg[1];
                            shreg   <= shreg >> 1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: logic/bram_mem.sv
`timescale 1ns/10ps

module bram_mem
    import soc_pkg::*;
(
    input  logic       clk,
    input  strb_t      we,
    input  word_addr_t addr,
    input  data_t      wdata,
    output data_t      rdata
);

    data_t mem [BRAM_WORDS];

    // one write enable per byte lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    // registered read, old word on a write cycle
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// File: logic/soc_pkg.sv
package soc_pkg;

    //////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////

    localparam int BRAM_WORDS = 256;
    localparam int BRAM_AW    = $clog2(BRAM_WORDS);

    typedef logic [31:0]        addr_t;
    typedef logic [31:0]        data_t;
    typedef logic [3:0]         strb_t;
    typedef logic [7:0]         byte_t;
    typedef logic [BRAM_AW-1:0] word_addr_t;

    // any strobe bit set marks a write
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  fault;
    } bus_rsp_t;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    localparam addr_t BRAM_BASE     = 32'h0000_0000;
    localparam addr_t UART_TX_ADDR  = 32'h1000_0000;
    localparam addr_t UART_RX_ADDR  = 32'h1000_0004;
    localparam addr_t UART_LSR_ADDR = 32'h1000_0008;
    localparam addr_t CLINT_BASE    = 32'h1100_0000;
    localparam addr_t FREQ_ADDR     = 32'h1200_0000;

    // offsets inside the 64 KiB clint window
    localparam logic [15:0] MSIP_OFS     = 16'h0000;
    localparam logic [15:0] MTIMECMP_OFS = 16'h4000;
    localparam logic [15:0] MTIME_OFS    = 16'hBFF8;

    //////////////////////////////////////////////////
    // rates
    //////////////////////////////////////////////////

    localparam data_t SYS_CLK_HZ = 32'd100_000_000;
    localparam int    BAUD_DIV   = 16;
    localparam int    HALF_DIV   = BAUD_DIV / 2;
    localparam int    TICK_DIV   = 4;

    typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;
    typedef logic [$clog2(TICK_DIV)-1:0] tick_cnt_t;

    // line status bits, tx idle is reported twice (bits 5 and 6)
    localparam int LSR_RX_READY = 0;
    localparam int LSR_TX_IDLE  = 5;

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        T_NONE, T_BRAM, T_UTX, T_URX, T_LSR, T_CLINT, T_FREQ, T_FAULT
    } target_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage
